// File: Bender.yml
package:
  name: ao_peripheral_subsystem

sources:
  - include_dirs:
      - source
    files:
      - source/ao_periph_pkg.sv
      - source/reg_bus_slice.sv
      - source/periph_addr_demux.sv
      - source/soc_ctrl.sv
      - source/fast_intr_ctrl.sv
      - source/gpio_ao.sv
      - source/ao_peripheral_subsystem.sv
  - target: test
    include_dirs:
      - source
    files:
      - verif/tb_ao_peripheral_subsystem.sv

// File: filelist.f
+incdir+source
source/ao_periph_pkg.sv
source/reg_bus_slice.sv
source/periph_addr_demux.sv
source/soc_ctrl.sv
source/fast_intr_ctrl.sv
source/gpio_ao.sv
source/ao_peripheral_subsystem.sv
verif/tb_ao_peripheral_subsystem.sv

// File: source/ao_periph_pkg.sv
//##########################################################################
// Types shared by the always-on register bus and its peripherals
//##########################################################################
`default_nettype none

`include "ao_periph_settings.svh"

package ao_periph_pkg;

  typedef logic [`AO_ADDR_W-1:0] addr_t;
  typedef logic [`AO_DATA_W-1:0] data_t;
  typedef logic [`AO_GPIO_W-1:0] gpio_t;
  typedef logic [`AO_FAST_INTR_W-1:0] fast_intr_t;
  typedef logic [`AO_SLOT_W-1:0] slot_t;

  // Held by the master until ready is seen at a rising edge
  typedef struct packed {
    logic  valid;
    logic  write;
    addr_t addr;
    data_t wdata;
  } reg_req_t;

  // rdata and error are valid in the cycle that ready is high
  typedef struct packed {
    logic  ready;
    data_t rdata;
    logic  error;
  } reg_rsp_t;

  // Request slice FSM
  typedef enum logic [1:0] {
    SLICE_IDLE = 2'd0,
    SLICE_BUSY = 2'd1,
    SLICE_RESP = 2'd2
  } slice_state_e;

endpackage : ao_periph_pkg

`default_nettype wire

// File: source/ao_periph_settings.svh
//##########################################################################
// Widths, slot decode and register offsets of the always-on block
// Every access is a full 32-bit word, so there are no byte strobes
//##########################################################################
`ifndef AO_PERIPH_SETTINGS_SVH
`define AO_PERIPH_SETTINGS_SVH

// Register bus
`define AO_ADDR_W 32
`define AO_DATA_W 32

// Peripheral pins and lines
`define AO_GPIO_W      8
`define AO_FAST_INTR_W 15

// Slot index sits above a 256-byte window
`define AO_SLOT_SHIFT     8
`define AO_SLOT_W         4
`define AO_SOC_CTRL_SLOT  0
`define AO_FAST_INTR_SLOT 1
`define AO_GPIO_SLOT      2

// Offsets inside each window
`define SOC_EXIT_VALID_OFS   32'h0
`define SOC_EXIT_VALUE_OFS   32'h4
`define SOC_BOOT_SEL_OFS     32'h8
`define FIC_PENDING_OFS      32'h0
`define FIC_CLEAR_OFS        32'h4
`define GPIO_IN_OFS          32'h0
`define GPIO_OUT_OFS         32'h4
`define GPIO_EN_OFS          32'h8
`define GPIO_INTR_EN_OFS     32'hC
`define GPIO_INTR_STATUS_OFS 32'h10

`endif

// File: source/ao_peripheral_subsystem.sv
//##########################################################################
// Always-on block: slice, slot demux and three peripherals
// A bus request completes three edges after it is first seen valid
//##########################################################################
`default_nettype none

module ao_peripheral_subsystem
  import ao_periph_pkg::*;
(
  input  logic       clk_i,
  input  logic       rst_i,
  input  reg_req_t   bus_req_i,
  output reg_rsp_t   bus_rsp_o,
  input  logic       boot_select_i,
  output logic       exit_valid_o,
  output data_t      exit_value_o,
  input  fast_intr_t fast_intr_i,
  output fast_intr_t fast_intr_o,
  input  gpio_t      cio_gpio_i,
  output gpio_t      cio_gpio_o,
  output gpio_t      cio_gpio_en_o,
  output gpio_t      intr_gpio_o
);

  reg_req_t slice_req;
  reg_rsp_t slice_rsp;
  reg_req_t soc_req;
  reg_rsp_t soc_rsp;
  reg_req_t fic_req;
  reg_rsp_t fic_rsp;
  reg_req_t gpio_req;
  reg_rsp_t gpio_rsp;

  reg_bus_slice reg_bus_slice_inst (
    .clk_i     (clk_i),
    .rst_i     (rst_i),
    .bus_req_i (bus_req_i),
    .bus_rsp_o (bus_rsp_o),
    .dev_req_o (slice_req),
    .dev_rsp_i (slice_rsp)
  );

  periph_addr_demux periph_addr_demux_inst (
    .req_i      (slice_req),
    .rsp_o      (slice_rsp),
    .soc_req_o  (soc_req),
    .fic_req_o  (fic_req),
    .gpio_req_o (gpio_req),
    .soc_rsp_i  (soc_rsp),
    .fic_rsp_i  (fic_rsp),
    .gpio_rsp_i (gpio_rsp)
  );

  soc_ctrl soc_ctrl_inst (
    .clk_i, .rst_i, .reg_req_i(soc_req), .reg_rsp_o(soc_rsp),
    .boot_select_i, .exit_valid_o, .exit_value_o
  );

  fast_intr_ctrl fast_intr_ctrl_inst (
    .clk_i, .rst_i, .reg_req_i(fic_req), .reg_rsp_o(fic_rsp),
    .fast_intr_i, .fast_intr_o
  );

  gpio_ao gpio_ao_inst (
    .clk_i, .rst_i, .reg_req_i(gpio_req), .reg_rsp_o(gpio_rsp),
    .cio_gpio_i, .cio_gpio_o, .cio_gpio_en_o, .intr_gpio_o
  );

endmodule : ao_peripheral_subsystem

`default_nettype wire

// File: source/fast_intr_ctrl.sv
//##########################################################################
// Sticky pending bits; an incoming line beats a same-cycle clear
//##########################################################################
`default_nettype none

`include "ao_periph_settings.svh"

module fast_intr_ctrl
  import ao_periph_pkg::*;
(
  input  logic       clk_i,
  input  logic       rst_i,
  input  reg_req_t   reg_req_i,
  output reg_rsp_t   reg_rsp_o,
  input  fast_intr_t fast_intr_i,
  output fast_intr_t fast_intr_o
);

  fast_intr_t pending_q;
  fast_intr_t clear_mask;

  // Write-one-to-clear mask
  always_comb begin
    clear_mask = '0;
    if (reg_req_i.valid && reg_req_i.write && (reg_req_i.addr == `FIC_CLEAR_OFS)) begin
      clear_mask = reg_req_i.wdata[`AO_FAST_INTR_W-1:0];
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      pending_q <= '0;
    end else begin
      pending_q <= (pending_q & ~clear_mask) | fast_intr_i;
    end
  end

  always_comb begin
    reg_rsp_o.ready = reg_req_i.valid;
    reg_rsp_o.error = 1'b0;
    reg_rsp_o.rdata = '0;
    if (reg_req_i.addr == `FIC_PENDING_OFS) begin
      reg_rsp_o.rdata[`AO_FAST_INTR_W-1:0] = pending_q;
    end
  end

  assign fast_intr_o = pending_q;

endmodule : fast_intr_ctrl

`default_nettype wire

// File: source/gpio_ao.sv
//##########################################################################
// Pins pass a two-flop synchronizer; only rising edges raise interrupts
//##########################################################################
`default_nettype none

`include "ao_periph_settings.svh"

module gpio_ao
  import ao_periph_pkg::*;
(
  input  logic     clk_i,
  input  logic     rst_i,
  input  reg_req_t reg_req_i,
  output reg_rsp_t reg_rsp_o,
  input  gpio_t    cio_gpio_i,
  output gpio_t    cio_gpio_o,
  output gpio_t    cio_gpio_en_o,
  output gpio_t    intr_gpio_o
);

  logic  wr_en;
  gpio_t wr_val;
  gpio_t sync1_q;
  gpio_t sync2_q;
  gpio_t rise;
  gpio_t status_clr;
  gpio_t out_q;
  gpio_t en_q;
  gpio_t intr_en_q;
  gpio_t intr_status_q;

  assign wr_en  = reg_req_i.valid && reg_req_i.write;
  assign wr_val = reg_req_i.wdata[`AO_GPIO_W-1:0];

  // Edge seen at the same clock that sync2 takes the new level
  assign rise       = sync1_q & ~sync2_q;
  assign status_clr = (wr_en && (reg_req_i.addr == `GPIO_INTR_STATUS_OFS)) ? wr_val : '0;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      sync1_q       <= '0;
      sync2_q       <= '0;
      out_q         <= '0;
      en_q          <= '0;
      intr_en_q     <= '0;
      intr_status_q <= '0;
    end else begin
      sync1_q       <= cio_gpio_i;
      sync2_q       <= sync1_q;
      intr_status_q <= (intr_status_q & ~status_clr) | (rise & intr_en_q);
      if (wr_en && (reg_req_i.addr == `GPIO_OUT_OFS)) out_q <= wr_val;
      if (wr_en && (reg_req_i.addr == `GPIO_EN_OFS)) en_q <= wr_val;
      if (wr_en && (reg_req_i.addr == `GPIO_INTR_EN_OFS)) intr_en_q <= wr_val;
    end
  end

  always_comb begin
    reg_rsp_o.ready = reg_req_i.valid;
    reg_rsp_o.error = 1'b0;
    reg_rsp_o.rdata = '0;
    case (reg_req_i.addr)
      `GPIO_IN_OFS:          reg_rsp_o.rdata[`AO_GPIO_W-1:0] = sync2_q;
      `GPIO_OUT_OFS:         reg_rsp_o.rdata[`AO_GPIO_W-1:0] = out_q;
      `GPIO_EN_OFS:          reg_rsp_o.rdata[`AO_GPIO_W-1:0] = en_q;
      `GPIO_INTR_EN_OFS:     reg_rsp_o.rdata[`AO_GPIO_W-1:0] = intr_en_q;
      `GPIO_INTR_STATUS_OFS: reg_rsp_o.rdata[`AO_GPIO_W-1:0] = intr_status_q;
      default: ;
    endcase
  end

  assign cio_gpio_o    = out_q;
  assign cio_gpio_en_o = en_q;
  assign intr_gpio_o   = intr_status_q;

endmodule : gpio_ao

`default_nettype wire

// File: source/periph_addr_demux.sv
//##########################################################################
// Combinational slot decode; peripherals get the in-window offset only
// Unmapped slots answer with error and zero data, no write is done
//##########################################################################
`default_nettype none

`include "ao_periph_settings.svh"

module periph_addr_demux
  import ao_periph_pkg::*;
(
  input  reg_req_t req_i,
  output reg_rsp_t rsp_o,

  output reg_req_t soc_req_o,
  output reg_req_t fic_req_o,
  output reg_req_t gpio_req_o,

  input  reg_rsp_t soc_rsp_i,
  input  reg_rsp_t fic_rsp_i,
  input  reg_rsp_t gpio_rsp_i
);

  slot_t    slot;
  reg_req_t fwd_req;

  assign slot = req_i.addr[`AO_SLOT_SHIFT +: `AO_SLOT_W];

  // Strip the window base from the address
  always_comb begin
    fwd_req      = req_i;
    fwd_req.addr = '0;
    fwd_req.addr[`AO_SLOT_SHIFT-1:0] = req_i.addr[`AO_SLOT_SHIFT-1:0];
  end

  always_comb begin
    soc_req_o        = fwd_req;
    soc_req_o.valid  = req_i.valid && (slot == `AO_SOC_CTRL_SLOT);
    fic_req_o        = fwd_req;
    fic_req_o.valid  = req_i.valid && (slot == `AO_FAST_INTR_SLOT);
    gpio_req_o       = fwd_req;
    gpio_req_o.valid = req_i.valid && (slot == `AO_GPIO_SLOT);
  end

  // Response of the selected slot
  always_comb begin
    case (slot)
      `AO_SOC_CTRL_SLOT:  rsp_o = soc_rsp_i;
      `AO_FAST_INTR_SLOT: rsp_o = fic_rsp_i;
      `AO_GPIO_SLOT:      rsp_o = gpio_rsp_i;
      default: begin
        // Decode error answered here
        rsp_o.ready = req_i.valid;
        rsp_o.rdata = '0;
        rsp_o.error = 1'b1;
      end
    endcase
  end

endmodule : periph_addr_demux

`default_nettype wire

// File: source/reg_bus_slice.sv
//##########################################################################
// One transfer in flight; the bus sees ready two edges after capture
//##########################################################################
`default_nettype none

module reg_bus_slice
  import ao_periph_pkg::*;
(
  input  logic     clk_i,
  input  logic     rst_i,
  input  reg_req_t bus_req_i,
  output reg_rsp_t bus_rsp_o,
  output reg_req_t dev_req_o,
  input  reg_rsp_t dev_rsp_i
);

  slice_state_e state_q;
  slice_state_e state_d;
  logic         capture;
  logic         dev_done;
  reg_req_t     req_q;
  data_t        rdata_q;
  logic         error_q;

  assign capture  = (state_q == SLICE_IDLE) && bus_req_i.valid;
  assign dev_done = (state_q == SLICE_BUSY) && dev_rsp_i.ready;

  always_comb begin
    state_d = state_q;
    case (state_q)
      SLICE_IDLE: if (capture) state_d = SLICE_BUSY;
      SLICE_BUSY: if (dev_done) state_d = SLICE_RESP;
      SLICE_RESP: state_d = SLICE_IDLE;
      default:    state_d = SLICE_IDLE;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q <= SLICE_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // Captured request and returned data
  always_ff @(posedge clk_i) begin
    if (capture) begin
      req_q <= bus_req_i;
    end
    if (dev_done) begin
      rdata_q <= dev_rsp_i.rdata;
      error_q <= dev_rsp_i.error;
    end
  end

  // Downstream only sees valid while busy
  always_comb begin
    dev_req_o       = req_q;
    dev_req_o.valid = (state_q == SLICE_BUSY);
  end

  assign bus_rsp_o.ready = (state_q == SLICE_RESP);
  assign bus_rsp_o.rdata = rdata_q;
  assign bus_rsp_o.error = error_q;

endmodule : reg_bus_slice

`default_nettype wire

// File: source/soc_ctrl.sv
//##########################################################################
// Exit status for the simulation host and boot select readback
//##########################################################################
`default_nettype none

`include "ao_periph_settings.svh"

module soc_ctrl
  import ao_periph_pkg::*;
(
  input  logic     clk_i,
  input  logic     rst_i,
  input  reg_req_t reg_req_i,
  output reg_rsp_t reg_rsp_o,
  input  logic     boot_select_i,
  output logic     exit_valid_o,
  output data_t    exit_value_o
);

  logic  wr_en;
  logic  exit_valid_q;
  data_t exit_value_q;

  assign wr_en = reg_req_i.valid && reg_req_i.write;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      exit_valid_q <= 1'b0;
      exit_value_q <= '0;
    end else if (wr_en) begin
      case (reg_req_i.addr)
        `SOC_EXIT_VALID_OFS: exit_valid_q <= reg_req_i.wdata[0];
        `SOC_EXIT_VALUE_OFS: exit_value_q <= reg_req_i.wdata;
        default: ;
      endcase
    end
  end

  // Always ready, unknown offsets read zero
  always_comb begin
    reg_rsp_o.ready = reg_req_i.valid;
    reg_rsp_o.error = 1'b0;
    reg_rsp_o.rdata = '0;
    case (reg_req_i.addr)
      `SOC_EXIT_VALID_OFS: reg_rsp_o.rdata[0] = exit_valid_q;
      `SOC_EXIT_VALUE_OFS: reg_rsp_o.rdata = exit_value_q;
      `SOC_BOOT_SEL_OFS:   reg_rsp_o.rdata[0] = boot_select_i;
      default: ;
    endcase
  end

  assign exit_valid_o = exit_valid_q;
  assign exit_value_o = exit_value_q;

endmodule : soc_ctrl

`default_nettype wire

// File: verif/tb_ao_peripheral_subsystem.sv
//##########################################################################
// Directed tests through the system bus port, one transfer at a time
// Inputs change on the falling edge, outputs are sampled there as well
//##########################################################################
`default_nettype none

`include "ao_periph_settings.svh"

module tb_ao_peripheral_subsystem
  import ao_periph_pkg::*;
();

  localparam int BUS_TIMEOUT = 20;

  logic       clk_i;
  logic       rst_i;
  reg_req_t   bus_req_i;
  reg_rsp_t   bus_rsp_o;
  logic       boot_select_i;
  logic       exit_valid_o;
  data_t      exit_value_o;
  fast_intr_t fast_intr_i;
  fast_intr_t fast_intr_o;
  gpio_t      cio_gpio_i;
  gpio_t      cio_gpio_o;
  gpio_t      cio_gpio_en_o;
  gpio_t      intr_gpio_o;

  integer seed;
  int     err_count;
  int     check_count;
  int     last_cycles;
  data_t  exit_value_exp;

  always #50 clk_i = ~clk_i;

  ao_peripheral_subsystem ao_peripheral_subsystem_inst (
    .clk_i         (clk_i),
    .rst_i         (rst_i),
    .bus_req_i     (bus_req_i),
    .bus_rsp_o     (bus_rsp_o),
    .boot_select_i (boot_select_i),
    .exit_valid_o  (exit_valid_o),
    .exit_value_o  (exit_value_o),
    .fast_intr_i   (fast_intr_i),
    .fast_intr_o   (fast_intr_o),
    .cio_gpio_i    (cio_gpio_i),
    .cio_gpio_o    (cio_gpio_o),
    .cio_gpio_en_o (cio_gpio_en_o),
    .intr_gpio_o   (intr_gpio_o)
  );

  function automatic addr_t slot_addr(input int slot, input logic [31:0] ofs);
    return (addr_t'(slot) << `AO_SLOT_SHIFT) | ofs;
  endfunction

  task automatic check_eq(input logic [31:0] got, input logic [31:0] exp, input string msg);
    check_count++;
    if (got !== exp) begin
      $display("FAILED at time %0t: %s, got %h expected %h", $time, msg, got, exp);
      err_count++;
    end
  endtask

  // Holds the request until ready has been seen at a rising edge
  task automatic bus_xfer(input logic write, input addr_t addr, input data_t wdata,
                          output data_t rdata, output logic error);
    int   cycles;
    logic seen;
    cycles = 0;
    seen   = 1'b0;
    rdata  = '0;
    error  = 1'b0;
    @(negedge clk_i);
    bus_req_i.valid = 1'b1;
    bus_req_i.write = write;
    bus_req_i.addr  = addr;
    bus_req_i.wdata = wdata;
    while (!seen && cycles < BUS_TIMEOUT) begin
      @(negedge clk_i);
      cycles++;
      if (bus_rsp_o.ready) begin
        seen  = 1'b1;
        rdata = bus_rsp_o.rdata;
        error = bus_rsp_o.error;
      end
    end
    last_cycles = cycles;
    if (seen) begin
      @(posedge clk_i);
      @(negedge clk_i);
    end else begin
      $display("Bus timeout: no ready within %0d cycles for address %h", BUS_TIMEOUT, addr);
      err_count++;
    end
    bus_req_i = '0;
  endtask

  task automatic bus_write(input addr_t addr, input data_t wdata, output logic error);
    data_t unused;
    bus_xfer(1'b1, addr, wdata, unused, error);
  endtask

  task automatic bus_read(input addr_t addr, output data_t rdata, output logic error);
    bus_xfer(1'b0, addr, '0, rdata, error);
  endtask

  task automatic report_test(input string name, input int errs_before);
    if (err_count == errs_before) $display("%s: passed", name);
    else $display("%s: %0d errors", name, err_count - errs_before);
  endtask

  task automatic test_reset_state();
    int errs;
    errs = err_count;
    check_eq(bus_rsp_o.ready, 0, "ready after reset");
    check_eq(exit_valid_o, 0, "exit_valid_o after reset");
    check_eq(exit_value_o, 0, "exit_value_o after reset");
    check_eq(fast_intr_o, 0, "fast_intr_o after reset");
    check_eq(cio_gpio_o, 0, "cio_gpio_o after reset");
    check_eq(cio_gpio_en_o, 0, "cio_gpio_en_o after reset");
    check_eq(intr_gpio_o, 0, "intr_gpio_o after reset");
    report_test("reset_state", errs);
  endtask

  // Ready shows after the second rising edge that sees valid
  task automatic test_slice_timing();
    int    errs;
    data_t rdata;
    logic  err;
    errs = err_count;
    for (int b = 0; b < 2; b++) begin
      @(negedge clk_i);
      boot_select_i = b[0];
      bus_read(slot_addr(`AO_SOC_CTRL_SLOT, `SOC_BOOT_SEL_OFS), rdata, err);
      check_eq(last_cycles, 2, "cycles until ready");
      check_eq(rdata, b, "BOOT_SEL readback");
      check_eq(err, 0, "BOOT_SEL error flag");
    end
    report_test("slice_timing", errs);
  endtask

  task automatic test_soc_ctrl();
    int    errs;
    data_t rdata;
    logic  err;
    errs = err_count;
    exit_value_exp = $random(seed);
    bus_write(slot_addr(`AO_SOC_CTRL_SLOT, `SOC_EXIT_VALUE_OFS), exit_value_exp, err);
    check_eq(exit_value_o, exit_value_exp, "exit_value_o after write");
    bus_read(slot_addr(`AO_SOC_CTRL_SLOT, `SOC_EXIT_VALUE_OFS), rdata, err);
    check_eq(rdata, exit_value_exp, "EXIT_VALUE readback");
    bus_write(slot_addr(`AO_SOC_CTRL_SLOT, `SOC_EXIT_VALID_OFS), 32'h1, err);
    check_eq(exit_valid_o, 1, "exit_valid_o set");
    bus_read(slot_addr(`AO_SOC_CTRL_SLOT, `SOC_EXIT_VALID_OFS), rdata, err);
    check_eq(rdata, 1, "EXIT_VALID readback");
    bus_write(slot_addr(`AO_SOC_CTRL_SLOT, `SOC_EXIT_VALID_OFS), 32'h0, err);
    check_eq(exit_valid_o, 0, "exit_valid_o cleared");
    report_test("soc_ctrl", errs);
  endtask

  task automatic test_fast_intr();
    int         errs;
    data_t      rdata;
    logic       err;
    fast_intr_t lines;
    fast_intr_t clr;
    errs  = err_count;
    // Line 0 is always cleared and line 1 always stays pending
    lines = fast_intr_t'($random(seed)) | 3;
    clr   = ((lines & fast_intr_t'($random(seed))) | 1) & ~fast_intr_t'(2);
    // One-cycle pulse
    @(negedge clk_i);
    fast_intr_i = lines;
    @(negedge clk_i);
    fast_intr_i = '0;
    check_eq(fast_intr_o, lines, "fast_intr_o after pulse");
    bus_read(slot_addr(`AO_FAST_INTR_SLOT, `FIC_PENDING_OFS), rdata, err);
    check_eq(rdata, lines, "PENDING after pulse");
    bus_write(slot_addr(`AO_FAST_INTR_SLOT, `FIC_CLEAR_OFS), clr, err);
    check_eq(fast_intr_o, lines & ~clr, "fast_intr_o after partial clear");
    bus_read(slot_addr(`AO_FAST_INTR_SLOT, `FIC_PENDING_OFS), rdata, err);
    check_eq(rdata, lines & ~clr, "PENDING after partial clear");
    report_test("fast_intr", errs);
  endtask

  task automatic test_gpio();
    int    errs;
    data_t rdata;
    logic  err;
    gpio_t out_val;
    gpio_t en_val;
    gpio_t pin_val;
    gpio_t ien;
    errs    = err_count;
    out_val = gpio_t'($random(seed));
    en_val  = gpio_t'($random(seed));
    pin_val = gpio_t'($random(seed)) | 1;
    // Pin 1 stays disabled so the enable mask is exercised
    ien     = (gpio_t'($random(seed)) | 1) & ~gpio_t'(2);
    bus_write(slot_addr(`AO_GPIO_SLOT, `GPIO_OUT_OFS), out_val, err);
    bus_write(slot_addr(`AO_GPIO_SLOT, `GPIO_EN_OFS), en_val, err);
    check_eq(cio_gpio_o, out_val, "cio_gpio_o");
    check_eq(cio_gpio_en_o, en_val, "cio_gpio_en_o");
    bus_read(slot_addr(`AO_GPIO_SLOT, `GPIO_OUT_OFS), rdata, err);
    check_eq(rdata, out_val, "OUT readback");
    bus_read(slot_addr(`AO_GPIO_SLOT, `GPIO_EN_OFS), rdata, err);
    check_eq(rdata, en_val, "EN readback");
    // Input through the synchronizer, interrupts still disabled
    @(negedge clk_i);
    cio_gpio_i = pin_val;
    repeat (2) @(negedge clk_i);
    bus_read(slot_addr(`AO_GPIO_SLOT, `GPIO_IN_OFS), rdata, err);
    check_eq(rdata, pin_val, "IN readback");
    cio_gpio_i = '0;
    repeat (3) @(negedge clk_i);
    check_eq(intr_gpio_o, 0, "no interrupt while disabled");
    bus_write(slot_addr(`AO_GPIO_SLOT, `GPIO_INTR_EN_OFS), ien, err);
    cio_gpio_i = '1;
    repeat (3) @(negedge clk_i);
    check_eq(intr_gpio_o, ien, "intr_gpio_o after rising edge");
    bus_read(slot_addr(`AO_GPIO_SLOT, `GPIO_INTR_STATUS_OFS), rdata, err);
    check_eq(rdata, ien, "INTR_STATUS readback");
    bus_write(slot_addr(`AO_GPIO_SLOT, `GPIO_INTR_STATUS_OFS), ien, err);
    check_eq(intr_gpio_o, 0, "intr_gpio_o after clear");
    cio_gpio_i = '0;
    report_test("gpio", errs);
  endtask

  task automatic test_decode_error();
    int    errs;
    data_t rdata;
    logic  err;
    errs = err_count;
    bus_read(slot_addr(5, `SOC_EXIT_VALUE_OFS), rdata, err);
    check_eq(err, 1, "unmapped read error flag");
    check_eq(rdata, 0, "unmapped read data");
    bus_xfer(1'b1, slot_addr(5, `SOC_EXIT_VALUE_OFS), ~exit_value_exp, rdata, err);
    check_eq(err, 1, "unmapped write error flag");
    check_eq(rdata, 0, "unmapped write data");
    bus_read(slot_addr(`AO_SOC_CTRL_SLOT, `SOC_EXIT_VALUE_OFS), rdata, err);
    check_eq(err, 0, "EXIT_VALUE error flag");
    check_eq(rdata, exit_value_exp, "EXIT_VALUE unchanged");
    check_eq(exit_value_o, exit_value_exp, "exit_value_o unchanged");
    report_test("decode_error", errs);
  endtask

  initial begin
    seed           = 87633;
    err_count      = 0;
    check_count    = 0;
    last_cycles    = 0;
    exit_value_exp = '0;
    clk_i          = 1'b0;
    rst_i          = 1'b1;
    bus_req_i      = '0;
    boot_select_i  = 1'b0;
    fast_intr_i    = '0;
    cio_gpio_i     = '0;
    repeat (8) @(posedge clk_i);
    @(negedge clk_i);
    rst_i = 1'b0;

    test_reset_state();
    test_slice_timing();
    test_soc_ctrl();
    test_fast_intr();
    test_gpio();
    test_decode_error();

    $display("Checks: %0d, errors: %0d", check_count, err_count);
    if (err_count == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule : tb_ao_peripheral_subsystem

`default_nettype wire
